// ==== hdl/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data and address width
`define XLEN 32

`define REG_AW 5

// data ram depth in words
`define RAM_WORDS 256

// also the number of credits
`define WBUF_DEPTH 4

`endif

// ==== hdl/isa_pkg.sv ====
`default_nettype none

`include "mem_settings.svh"

package isa_pkg;

  typedef enum logic [3:0] {
    op_alu   = 4'd0,
    op_lb    = 4'd1,
    op_lbu   = 4'd2,
    op_lh    = 4'd3,
    op_lhu   = 4'd4,
    op_lw    = 4'd5,
    op_sb    = 4'd6,
    op_sh    = 4'd7,
    op_sw    = 4'd8,
    op_fence = 4'd9
  } mem_op_t;

  // instruction as it leaves execute
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    mem_op_t            op;
    logic [`XLEN-1:0]   address;
    logic [`XLEN-1:0]   sdata;   // store data, not yet on its lanes
    logic [`XLEN-1:0]   wdata;   // alu result
    logic [`REG_AW-1:0] waddr;
    logic               wren;
  } exec_result_t;

endpackage

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

  // one write buffer entry
  typedef struct packed {
    logic [`XLEN-3:0]   addr;      // word address
    logic [`XLEN-1:0]   wdata;
    logic [`XLEN/8-1:0] wstrb;     // zero for a load
    logic               load;
    isa_pkg::mem_op_t   load_op;
    logic [1:0]         offset;
  } mem_req_t;

  typedef enum logic [3:0] {
    cause_load_misaligned  = 4'd4,
    cause_store_misaligned = 4'd6
  } trap_cause_t;

endpackage

`default_nettype wire

// ==== hdl/mem_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

interface mem_bus_if;

  logic               req_valid;
  mem_pkg::mem_req_t  req;
  logic               credit_return;  // one pulse per retired entry
  logic               rsp_valid;
  logic [`XLEN-1:0]   rdata;

  modport stage (
    output req_valid,
    output req,
    input  credit_return,
    input  rsp_valid,
    input  rdata
  );

  modport buffer (
    input  req_valid,
    input  req,
    output credit_return,
    output rsp_valid,
    output rdata
  );

endinterface

`default_nettype wire

// ==== hdl/lsu_align.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module lsu_align (
  input  wire logic [`XLEN-1:0]   addr,
  input  wire logic [`XLEN-1:0]   sdata,
  input  wire isa_pkg::mem_op_t   op,
  input  wire logic [`XLEN-1:0]   rdata,
  output logic [`XLEN-1:0]        wdata,
  output logic [`XLEN/8-1:0]      wstrb,
  output logic                    misaligned,
  output logic [`XLEN-1:0]        ldata
);

  localparam int NB = `XLEN / 8;

  logic [1:0]  off;
  logic [7:0]  lbyte;
  logic [15:0] lhalf;

  assign off   = addr[1:0];
  assign lbyte = rdata[8*off +: 8];
  assign lhalf = rdata[16*off[1] +: 16];

  always_comb begin
    wdata      = sdata;
    wstrb      = '0;
    misaligned = 1'b0;
    case (op)
      isa_pkg::op_sb: begin
        wdata = {NB{sdata[7:0]}};  // byte on every lane
        wstrb = NB'(1) << off;
      end
      isa_pkg::op_sh: begin
        wdata      = {(NB/2){sdata[15:0]}};
        wstrb      = NB'(3) << off;
        misaligned = off[0];
      end
      isa_pkg::op_sw: begin
        wstrb      = '1;
        misaligned = off != 2'b00;
      end
      isa_pkg::op_lh, isa_pkg::op_lhu: misaligned = off[0];
      isa_pkg::op_lw: misaligned = off != 2'b00;
      default: misaligned = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      isa_pkg::op_lb:  ldata = {{(`XLEN-8){lbyte[7]}}, lbyte};
      isa_pkg::op_lbu: ldata = {{(`XLEN-8){1'b0}}, lbyte};
      isa_pkg::op_lh:  ldata = {{(`XLEN-16){lhalf[15]}}, lhalf};
      isa_pkg::op_lhu: ldata = {{(`XLEN-16){1'b0}}, lhalf};
      default:         ldata = rdata;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module data_ram (
  input  wire logic                         clk,
  input  wire logic                         en,
  input  wire logic                         we,
  input  wire logic [$clog2(`RAM_WORDS)-1:0] addr,
  input  wire logic [`XLEN-1:0]             wdata,
  input  wire logic [`XLEN/8-1:0]           wstrb,
  output logic [`XLEN-1:0]                  rdata
);

  logic [`XLEN-1:0] mem [`RAM_WORDS];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int i = 0; i < `XLEN/8; i++) begin
          if (wstrb[i]) begin
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];  // byte lane write
          end
        end
      end
      rdata <= mem[addr];  // old word on a write
    end
  end

endmodule

`default_nettype wire

// ==== hdl/write_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module write_buffer (
  input  wire logic                         clk,
  input  wire logic                         rst,
  mem_bus_if.buffer                         bus,
  output logic                              ram_en,
  output logic                              ram_we,
  output logic [$clog2(`RAM_WORDS)-1:0]     ram_addr,
  output logic [`XLEN-1:0]                  ram_wdata,
  output logic [`XLEN/8-1:0]                ram_wstrb,
  input  wire logic [`XLEN-1:0]             ram_rdata
);

  localparam int PW = $clog2(`WBUF_DEPTH);
  localparam int CW = $clog2(`WBUF_DEPTH + 1);

  mem_pkg::mem_req_t queue [`WBUF_DEPTH];
  mem_pkg::mem_req_t head_req;
  logic [PW-1:0]     head;
  logic [PW-1:0]     tail;
  logic [CW-1:0]     count;
  logic              busy;   // head entry is at the ram
  logic              issue;
  logic              push;
  logic              pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    if (p == PW'(`WBUF_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign head_req = queue[head];
  assign push     = bus.req_valid;
  assign pop      = busy;  // ram answers one cycle after issue
  assign issue    = !busy && count != '0;

  assign ram_en    = issue;
  assign ram_we    = issue && !head_req.load;
  assign ram_addr  = head_req.addr[$clog2(`RAM_WORDS)-1:0];
  assign ram_wdata = head_req.wdata;
  assign ram_wstrb = head_req.wstrb;

  assign bus.credit_return = busy;
  assign bus.rsp_valid     = busy && head_req.load;
  assign bus.rdata         = ram_rdata;

  always_ff @(posedge clk) begin
    if (push) begin
      queue[tail] <= bus.req;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      busy  <= 1'b0;
    end else begin
      busy <= issue;
      if (push) begin
        tail <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the stage must never send without a credit
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
    push |-> count != CW'(`WBUF_DEPTH));

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module memory_stage (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 in_valid,
  input  wire isa_pkg::exec_result_t in_instr,
  input  wire logic                 flush,
  output logic                      stall,
  output logic                      wb_wren,
  output logic [`REG_AW-1:0]        wb_waddr,
  output logic [`XLEN-1:0]          wb_wdata,
  output logic                      trap_valid,
  output mem_pkg::trap_cause_t      trap_cause,
  output logic [`XLEN-1:0]          trap_epc,
  output logic [`XLEN-1:0]          trap_tval,
  mem_bus_if.stage                  bus,
  output logic [`XLEN-1:0]          al_addr,
  output logic [`XLEN-1:0]          al_sdata,
  output isa_pkg::mem_op_t          al_op,
  input  wire logic [`XLEN-1:0]     al_wdata,
  input  wire logic [`XLEN/8-1:0]   al_wstrb,
  input  wire logic                 al_misaligned,
  output logic [`XLEN-1:0]          al_rdata,
  input  wire logic [`XLEN-1:0]     al_ldata
);

  localparam int CW = $clog2(`WBUF_DEPTH + 1);
  localparam logic [CW-1:0] FULL = CW'(`WBUF_DEPTH);

  isa_pkg::exec_result_t r;
  logic                  r_valid;
  logic                  waiting;   // held load has its request out
  logic                  discard;   // response of a flushed load still due
  logic [CW-1:0]         credits;
  logic                  is_load;
  logic                  is_store;
  logic                  is_fence;
  logic                  is_alu;
  logic                  live;
  logic                  sent;
  logic                  load_done;
  logic                  retire;
  logic                  done;
  logic                  kill_wait;
  logic                  accept;
  mem_pkg::mem_req_t     req;

  assign is_load  = r.op inside {isa_pkg::op_lb, isa_pkg::op_lbu, isa_pkg::op_lh,
                                 isa_pkg::op_lhu, isa_pkg::op_lw};
  assign is_store = r.op inside {isa_pkg::op_sb, isa_pkg::op_sh, isa_pkg::op_sw};
  assign is_fence = r.op == isa_pkg::op_fence;
  assign is_alu   = r.op == isa_pkg::op_alu;

  assign live      = r_valid && !flush;
  assign sent      = live && (is_load || is_store) && !al_misaligned && !waiting &&
                     credits != '0;
  assign load_done = live && waiting && bus.rsp_valid;

  always_comb begin
    retire = 1'b1;  // alu ops and traps
    if (is_fence) begin
      retire = credits == FULL;  // buffer drained
    end else if ((is_load || is_store) && !al_misaligned) begin
      retire = is_store ? sent : load_done;
    end
  end

  assign done      = r_valid && (flush || retire);
  assign kill_wait = r_valid && flush && waiting && !bus.rsp_valid;
  assign stall     = (r_valid && !done) || kill_wait || (discard && !bus.rsp_valid);
  assign accept    = in_valid && !stall;

  always_ff @(posedge clk) begin
    if (accept) begin
      r <= in_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r_valid <= 1'b0;
      waiting <= 1'b0;
      discard <= 1'b0;
      credits <= FULL;
    end else begin
      if (accept) begin
        r_valid <= 1'b1;
      end else if (done) begin
        r_valid <= 1'b0;
      end
      if (sent && is_load) begin
        waiting <= 1'b1;
      end else if (bus.rsp_valid || flush) begin
        waiting <= 1'b0;
      end
      if (kill_wait) begin
        discard <= 1'b1;
      end else if (bus.rsp_valid) begin
        discard <= 1'b0;
      end
      credits <= credits - CW'(sent) + CW'(bus.credit_return);
    end
  end

  assign al_addr  = r.address;
  assign al_sdata = r.sdata;
  assign al_op    = r.op;
  assign al_rdata = bus.rdata;

  always_comb begin
    req.addr    = r.address[`XLEN-1:2];
    req.wdata   = al_wdata;
    req.wstrb   = al_wstrb;  // aligner gives zero for loads
    req.load    = is_load;
    req.load_op = r.op;
    req.offset  = r.address[1:0];
  end

  assign bus.req_valid = sent;
  assign bus.req       = req;

  assign wb_wren  = (live && is_alu && r.wren && r.waddr != '0) ||
                    (load_done && r.waddr != '0);
  assign wb_waddr = r.waddr;
  assign wb_wdata = is_load ? al_ldata : r.wdata;

  assign trap_valid = live && (is_load || is_store) && al_misaligned;
  assign trap_cause = is_load ? mem_pkg::cause_load_misaligned
                              : mem_pkg::cause_store_misaligned;
  assign trap_epc   = r.pc;
  assign trap_tval  = r.address;

  // a response only for a load still in flight
  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst)
    bus.rsp_valid |-> waiting || discard);

  // credit discipline toward the write buffer
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst)
    credits <= FULL);

  a_wb_trap_excl: assert property (@(posedge clk) disable iff (!rst)
    !(wb_wren && trap_valid));

endmodule

`default_nettype wire

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsystem (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                in_valid,
  input  wire logic [`XLEN-1:0]    in_pc,
  input  wire isa_pkg::mem_op_t    in_op,
  input  wire logic [`XLEN-1:0]    in_address,
  input  wire logic [`XLEN-1:0]    in_sdata,
  input  wire logic [`XLEN-1:0]    in_wdata,
  input  wire logic [`REG_AW-1:0]  in_waddr,
  input  wire logic                in_wren,
  input  wire logic                flush,
  output logic                     stall,
  output logic                     wb_wren,
  output logic [`REG_AW-1:0]       wb_waddr,
  output logic [`XLEN-1:0]         wb_wdata,
  output logic                     trap_valid,
  output mem_pkg::trap_cause_t     trap_cause,
  output logic [`XLEN-1:0]         trap_epc,
  output logic [`XLEN-1:0]         trap_tval
);

  isa_pkg::exec_result_t             in_instr;
  logic [`XLEN-1:0]                  al_addr;
  logic [`XLEN-1:0]                  al_sdata;
  isa_pkg::mem_op_t                  al_op;
  logic [`XLEN-1:0]                  al_wdata;
  logic [`XLEN/8-1:0]                al_wstrb;
  logic                              al_misaligned;
  logic [`XLEN-1:0]                  al_rdata;
  logic [`XLEN-1:0]                  al_ldata;
  logic                              ram_en;
  logic                              ram_we;
  logic [$clog2(`RAM_WORDS)-1:0]     ram_addr;
  logic [`XLEN-1:0]                  ram_wdata;
  logic [`XLEN/8-1:0]                ram_wstrb;
  logic [`XLEN-1:0]                  ram_rdata;

  mem_bus_if bus ();

  always_comb begin
    in_instr.pc      = in_pc;
    in_instr.op      = in_op;
    in_instr.address = in_address;
    in_instr.sdata   = in_sdata;
    in_instr.wdata   = in_wdata;
    in_instr.waddr   = in_waddr;
    in_instr.wren    = in_wren;
  end

  memory_stage u_stage (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .flush         (flush),
    .stall         (stall),
    .wb_wren       (wb_wren),
    .wb_waddr      (wb_waddr),
    .wb_wdata      (wb_wdata),
    .trap_valid    (trap_valid),
    .trap_cause    (trap_cause),
    .trap_epc      (trap_epc),
    .trap_tval     (trap_tval),
    .bus           (bus.stage),
    .al_addr       (al_addr),
    .al_sdata      (al_sdata),
    .al_op         (al_op),
    .al_wdata      (al_wdata),
    .al_wstrb      (al_wstrb),
    .al_misaligned (al_misaligned),
    .al_rdata      (al_rdata),
    .al_ldata      (al_ldata)
  );

  lsu_align u_align (
    .addr       (al_addr),
    .sdata      (al_sdata),
    .op         (al_op),
    .rdata      (al_rdata),
    .wdata      (al_wdata),
    .wstrb      (al_wstrb),
    .misaligned (al_misaligned),
    .ldata      (al_ldata)
  );

  write_buffer u_wbuf (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus.buffer),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_rdata (ram_rdata)
  );

  data_ram u_ram (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .wstrb (ram_wstrb),
    .rdata (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== test/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module tb_mem_subsystem;

  localparam int TIMEOUT = 200;  // cycles per wait

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  logic [`XLEN-1:0]     in_pc;
  isa_pkg::mem_op_t     in_op;
  logic [`XLEN-1:0]     in_address;
  logic [`XLEN-1:0]     in_sdata;
  logic [`XLEN-1:0]     in_wdata;
  logic [`REG_AW-1:0]   in_waddr;
  logic                 in_wren;
  logic                 flush;
  logic                 stall;
  logic                 wb_wren;
  logic [`REG_AW-1:0]   wb_waddr;
  logic [`XLEN-1:0]     wb_wdata;
  logic                 trap_valid;
  mem_pkg::trap_cause_t trap_cause;
  logic [`XLEN-1:0]     trap_epc;
  logic [`XLEN-1:0]     trap_tval;

  logic [7:0]           ref_mem [0:4*`RAM_WORDS-1];  // byte-wise reference model
  integer               seed;
  logic [`XLEN-1:0]     pc;
  logic [`XLEN-1:0]     last_pc;
  int                   stall_cycles;

  mem_subsystem UUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_pc      (in_pc),
    .in_op      (in_op),
    .in_address (in_address),
    .in_sdata   (in_sdata),
    .in_wdata   (in_wdata),
    .in_waddr   (in_waddr),
    .in_wren    (in_wren),
    .flush      (flush),
    .stall      (stall),
    .wb_wren    (wb_wren),
    .wb_waddr   (wb_waddr),
    .wb_wdata   (wb_wdata),
    .trap_valid (trap_valid),
    .trap_cause (trap_cause),
    .trap_epc   (trap_epc),
    .trap_tval  (trap_tval)
  );

  always #5 clk = ~clk;

  task automatic fail_stop();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    fail_stop();
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_reg(input string name, input logic [`REG_AW-1:0] got,
                           input logic [`REG_AW-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_cause(input string name, input mem_pkg::trap_cause_t got,
                             input mem_pkg::trap_cause_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      fail_stop();
    end
  endtask

  function automatic void model_store(input isa_pkg::mem_op_t op,
                                      input logic [`XLEN-1:0] addr,
                                      input logic [`XLEN-1:0] data);
    int nbytes;
    nbytes = (op == isa_pkg::op_sb) ? 1 : (op == isa_pkg::op_sh) ? 2 : 4;
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[int'(addr) + i] = data[8*i +: 8];  // little endian
    end
  endfunction

  function automatic logic [`XLEN-1:0] expected_load(input isa_pkg::mem_op_t op,
                                                     input logic [`XLEN-1:0] addr);
    logic [7:0]  b;
    logic [15:0] h;
    int          a;
    a = int'(addr);
    b = ref_mem[a];
    h = {ref_mem[a+1], ref_mem[a]};
    case (op)
      isa_pkg::op_lb:  return {{(`XLEN-8){b[7]}}, b};
      isa_pkg::op_lbu: return {{(`XLEN-8){1'b0}}, b};
      isa_pkg::op_lh:  return {{(`XLEN-16){h[15]}}, h};
      isa_pkg::op_lhu: return {{(`XLEN-16){1'b0}}, h};
      default:         return {ref_mem[a+3], ref_mem[a+2], h};
    endcase
  endfunction

  // returns right after the edge that accepts the instruction
  task automatic send(input isa_pkg::mem_op_t op, input logic [`XLEN-1:0] addr,
                      input logic [`XLEN-1:0] sdata, input logic [`XLEN-1:0] wdata,
                      input logic [`REG_AW-1:0] waddr, input logic wren);
    int n;
    @(negedge clk);
    in_pc      = pc;
    in_op      = op;
    in_address = addr;
    in_sdata   = sdata;
    in_wdata   = wdata;
    in_waddr   = waddr;
    in_wren    = wren;
    in_valid   = 1'b1;
    n = 0;
    #1;
    while (stall && n < TIMEOUT) begin
      stall_cycles++;
      n++;
      @(negedge clk);
      #1;
    end
    if (stall) begin
      timed_out("stall to fall before acceptance");
    end else begin
      @(posedge clk);
      last_pc = pc;
      pc      = pc + 4;
    end
  endtask

  // leaves the testbench sampling inside the stage cycle
  task automatic enter_stage();
    @(negedge clk);
    in_valid = 1'b0;
    #1;
  endtask

  task automatic wait_wb();
    int n;
    enter_stage();
    n = 0;
    while (!wb_wren && n < TIMEOUT) begin
      n++;
      @(negedge clk);
      #1;
    end
    if (!wb_wren) begin
      timed_out("load writeback");
    end
  endtask

  task automatic wait_idle();
    int n;
    enter_stage();
    n = 0;
    while (stall && n < TIMEOUT) begin
      n++;
      @(negedge clk);
      #1;
    end
    if (stall) begin
      timed_out("stall to clear");
    end
  endtask

  task automatic store(input isa_pkg::mem_op_t op, input logic [`XLEN-1:0] addr,
                       input logic [`XLEN-1:0] data);
    send(op, addr, data, '0, '0, 1'b0);
    model_store(op, addr, data);
  endtask

  task automatic load_check(input isa_pkg::mem_op_t op, input logic [`XLEN-1:0] addr);
    send(op, addr, '0, '0, 5'd10, 1'b1);
    wait_wb();
    check_reg("wb_waddr", wb_waddr, 5'd10);
    check_word("wb_wdata", wb_wdata, expected_load(op, addr));
  endtask

  task automatic trap_check(input isa_pkg::mem_op_t op, input logic [`XLEN-1:0] addr,
                            input mem_pkg::trap_cause_t cause);
    send(op, addr, 32'h5a5a_5a5a, '0, 5'd12, 1'b1);
    enter_stage();
    check_flag("trap_valid", trap_valid, 1'b1);
    check_cause("trap_cause", trap_cause, cause);
    check_word("trap_tval", trap_tval, addr);
    check_word("trap_epc", trap_epc, last_pc);
    check_flag("wb_wren", wb_wren, 1'b0);
  endtask

  task automatic alu_passthrough();
    logic [`XLEN-1:0] data;
    data = $random(seed);
    send(isa_pkg::op_alu, '0, '0, data, 5'd5, 1'b1);
    enter_stage();
    check_flag("wb_wren", wb_wren, 1'b1);
    check_reg("wb_waddr", wb_waddr, 5'd5);
    check_word("wb_wdata", wb_wdata, data);
    send(isa_pkg::op_alu, '0, '0, data, 5'd0, 1'b1);  // x0 is never written
    enter_stage();
    check_flag("wb_wren", wb_wren, 1'b0);
    @(negedge clk);
    #1;
    check_flag("wb_wren", wb_wren, 1'b0);
  endtask

  task automatic word_store_load();
    for (int i = 0; i < 8; i++) begin
      store(isa_pkg::op_sw, 32'h100 + 4*i, $random(seed));
    end
    for (int i = 0; i < 8; i++) begin
      load_check(isa_pkg::op_lw, 32'h100 + 4*i);
    end
  endtask

  task automatic subword_access();
    logic [`XLEN-1:0] data;
    store(isa_pkg::op_sw, 32'h120, $random(seed));
    store(isa_pkg::op_sw, 32'h124, $random(seed));
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      store(isa_pkg::op_sb, 32'h120 + i, i[0] ? data | 32'h80 : data & ~32'h80);
    end
    for (int i = 0; i < 4; i += 2) begin
      data = $random(seed);
      store(isa_pkg::op_sh, 32'h124 + i, i == 2 ? data | 32'h8000 : data & ~32'h8000);
    end
    for (int i = 0; i < 4; i++) begin
      load_check(isa_pkg::op_lb, 32'h120 + i);
      load_check(isa_pkg::op_lbu, 32'h120 + i);
    end
    for (int i = 0; i < 8; i += 2) begin
      load_check(isa_pkg::op_lh, 32'h120 + i);
      load_check(isa_pkg::op_lhu, 32'h120 + i);
    end
  endtask

  task automatic backpressure_fence();
    stall_cycles = 0;
    for (int i = 0; i < 3*`WBUF_DEPTH; i++) begin
      store(isa_pkg::op_sw, 32'h200 + 4*i, $random(seed));
    end
    send(isa_pkg::op_fence, '0, '0, '0, '0, 1'b0);
    enter_stage();
    check_flag("stall while fence drains", stall, 1'b1);  // last store still queued
    wait_idle();  // fence holds until every credit is back
    check_flag("stall seen during store burst", stall_cycles != 0, 1'b1);
    for (int i = 0; i < 3*`WBUF_DEPTH; i++) begin
      load_check(isa_pkg::op_lw, 32'h200 + 4*i);
    end
  endtask

  task automatic misaligned_trap();
    trap_check(isa_pkg::op_lh, 32'h101, mem_pkg::cause_load_misaligned);
    trap_check(isa_pkg::op_sw, 32'h102, mem_pkg::cause_store_misaligned);
    load_check(isa_pkg::op_lw, 32'h100);
  endtask

  task automatic flush_kill();
    int n;
    send(isa_pkg::op_sw, 32'h104, 32'hdead_beef, '0, '0, 1'b0);
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b1;  // kills the store in its stage cycle
    @(negedge clk);
    flush = 1'b0;
    wait_idle();
    load_check(isa_pkg::op_lw, 32'h104);
    send(isa_pkg::op_lw, 32'h108, '0, '0, 5'd11, 1'b1);
    enter_stage();
    @(negedge clk);
    flush = 1'b1;  // request is outstanding now
    @(negedge clk);
    flush = 1'b0;
    n = 0;
    #1;
    while (stall && n < TIMEOUT) begin
      check_flag("wb_wren", wb_wren, 1'b0);
      n++;
      @(negedge clk);
      #1;
    end
    if (stall) begin
      timed_out("flushed load to drain");
    end else begin
      check_flag("wb_wren", wb_wren, 1'b0);
      load_check(isa_pkg::op_lw, 32'h10c);
    end
  endtask

  initial begin
    seed         = 32'hb907_55bd;
    clk          = 1'b0;
    rst          = 1'b0;
    in_valid     = 1'b0;
    in_pc        = '0;
    in_op        = isa_pkg::op_alu;
    in_address   = '0;
    in_sdata     = '0;
    in_wdata     = '0;
    in_waddr     = '0;
    in_wren      = 1'b0;
    flush        = 1'b0;
    pc           = 32'h0000_1000;
    last_pc      = '0;
    stall_cycles = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    #1;
    check_flag("stall", stall, 1'b0);
    check_flag("wb_wren", wb_wren, 1'b0);
    check_flag("trap_valid", trap_valid, 1'b0);
    alu_passthrough();
    word_store_load();
    subword_access();
    backpressure_fence();
    misaligned_trap();
    flush_kill();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/mem_pkg.sv
hdl/mem_bus_if.sv
hdl/lsu_align.sv
hdl/data_ram.sv
hdl/write_buffer.sv
hdl/memory_stage.sv
hdl/mem_subsystem.sv
test/tb_mem_subsystem.sv
